//--- include/periph_config.svh
/*
 * Peripheral hub configuration
 * Address map, register offsets and reset pin functions
 */
`ifndef PERIPH_CONFIG_SVH
`define PERIPH_CONFIG_SVH

// Bus and pin widths
`define PERIPH_ADDR_W 11
`define PERIPH_DATA_W 32
`define PERIPH_PIN_W 8
`define PERIPH_SLOTS 16

// Slot assignment
`define SLOT_GPIO 1
`define SLOT_WORD_REG 4
`define SLOT_BYTE_REG 0

// Register offsets within a slot
`define GPIO_OUT_OFS 0
`define GPIO_IN_OFS 4
`define GPIO_FUNC_BASE 32
`define WORD_IRQ_SET_OFS 4
`define WORD_IRQ_CLR_OFS 8

// Reset pin functions as {bank, slot}
`define PIN_FUNC_RESET_LOW 5'h04
`define PIN_FUNC_RESET_HIGH 5'h01

`endif

//--- src/periph_bus_pkg.sv
/*
 * Bus transaction types
 * Access sizes, the core request and the per-slot response
 */
`include "periph_config.svh"

package periph_bus_pkg;

    // Same encoding as the core's size fields, all ones means idle
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10,
        SIZE_NONE = 2'b11
    } access_size_e;

    // Request as presented by the core
    typedef struct packed {
        logic [`PERIPH_ADDR_W-1:0] addr;
        logic [`PERIPH_DATA_W-1:0] wdata;
        access_size_e              write_size;
        access_size_e              read_size;
    } bus_req_t;

    // Response of one user slot
    typedef struct packed {
        logic [`PERIPH_DATA_W-1:0] rdata;
        logic                      ready;
        logic [`PERIPH_PIN_W-1:0]  pins;
    } slot_rsp_t;

endpackage

//--- src/periph_map_pkg.sv
/*
 * Address map types
 * Bank select, slot index and the per-pin function code
 */
`include "periph_config.svh"

package periph_map_pkg;

    // Selected by address bit 10
    typedef enum logic {
        BANK_USER   = 1'b0,
        BANK_SIMPLE = 1'b1
    } bank_e;

    typedef logic [$clog2(`PERIPH_SLOTS)-1:0] slot_idx_t;

    // Written by software into the GPIO function registers
    typedef struct packed {
        bank_e     bank;
        slot_idx_t slot;
    } pin_func_t;

endpackage

//--- src/periph_addr_decode.sv
/*
 * Peripheral address decoder
 * Gates the request to the addressed slot and returns its data and ready
 */
`timescale 1ns/1ns
`include "periph_config.svh"

module periph_addr_decode (
    input  periph_bus_pkg::bus_req_t  i_req,
    input  periph_bus_pkg::slot_rsp_t i_user_rsp [`PERIPH_SLOTS],
    input  logic [7:0]                i_simple_rdata,
    output periph_bus_pkg::bus_req_t  o_user_req [`PERIPH_SLOTS],
    output logic                      o_simple_wr,
    output logic [3:0]                o_simple_addr,
    output logic [7:0]                o_simple_wdata,
    output logic [`PERIPH_DATA_W-1:0] o_rdata,
    output logic                      o_rdy
);

    periph_map_pkg::bank_e     bank;
    periph_map_pkg::slot_idx_t user_slot;
    periph_map_pkg::slot_idx_t simple_slot;
    logic                      byte_reg_sel;

    assign bank        = periph_map_pkg::bank_e'(i_req.addr[`PERIPH_ADDR_W-1]);
    assign user_slot   = i_req.addr[9:6];
    assign simple_slot = i_req.addr[7:4];

    assign byte_reg_sel = (bank == periph_map_pkg::BANK_SIMPLE) &&
                          (simple_slot == `SLOT_BYTE_REG);

    // Only the addressed user slot sees a live access
    always_comb begin
        for (int s = 0; s < `PERIPH_SLOTS; s++) begin
            o_user_req[s] = i_req;
            if (bank != periph_map_pkg::BANK_USER || user_slot != s) begin
                o_user_req[s].write_size = periph_bus_pkg::SIZE_NONE;
                o_user_req[s].read_size  = periph_bus_pkg::SIZE_NONE;
            end
        end
    end

    // Simple bank is byte wide with no handshake
    assign o_simple_wr    = byte_reg_sel && (i_req.write_size != periph_bus_pkg::SIZE_NONE);
    assign o_simple_addr  = i_req.addr[3:0];
    assign o_simple_wdata = i_req.wdata[7:0];

    always_comb begin
        if (bank == periph_map_pkg::BANK_SIMPLE) begin
            o_rdata = {{(`PERIPH_DATA_W-8){1'b0}}, byte_reg_sel ? i_simple_rdata : 8'h00};
            o_rdy   = 1'b1;
        end else begin
            o_rdata = i_user_rsp[user_slot].rdata;
            o_rdy   = i_user_rsp[user_slot].ready;
        end
    end

endmodule

//--- src/periph_read_buffer.sv
/*
 * Read data buffer
 * Registers read data and ready, holds data until the core signals
 * read complete, and acknowledges writes in the same cycle
 */
`timescale 1ns/1ns
`include "periph_config.svh"

module periph_read_buffer (
    input  logic                         clk,
    input  logic                         rst_n,
    input  periph_bus_pkg::access_size_e i_read_size,
    input  periph_bus_pkg::access_size_e i_write_size,
    input  logic [`PERIPH_DATA_W-1:0]    i_rdata,
    input  logic                         i_rdy,
    input  logic                         i_data_read_complete,
    output logic [`PERIPH_DATA_W-1:0]    o_data_out,
    output logic                         o_data_ready
);

    logic                      read_req;
    logic                      capture;
    logic                      hold_q;
    logic                      ready_q;
    logic [`PERIPH_DATA_W-1:0] data_q;

    assign read_req = (i_read_size != periph_bus_pkg::SIZE_NONE);
    assign capture  = read_req && i_rdy && !hold_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_q  <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            // A new capture wins over a complete in the same cycle
            if (capture) begin
                hold_q <= 1'b1;
            end else if (i_data_read_complete) begin
                hold_q <= 1'b0;
            end
            ready_q <= read_req && i_rdy;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_q <= '0;
        end else if (capture) begin
            data_q <= i_rdata;
        end
    end

    assign o_data_out   = data_q;
    assign o_data_ready = ready_q || (i_write_size != periph_bus_pkg::SIZE_NONE);

endmodule

//--- src/gpio_ctrl.sv
/*
 * GPIO controller
 * Output register, input pin readback and one function select
 * register per output pin
 */
`timescale 1ns/1ns
`include "periph_config.svh"

module gpio_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  periph_bus_pkg::bus_req_t  i_req,
    input  logic [`PERIPH_PIN_W-1:0]  i_ui_in,
    output periph_bus_pkg::slot_rsp_t o_rsp,
    output periph_map_pkg::pin_func_t o_pin_func [`PERIPH_PIN_W]
);

    logic [5:0]                ofs;
    logic                      wr;
    logic                      func_hit;
    logic [2:0]                func_idx;
    logic [`PERIPH_PIN_W-1:0]  gpio_out_q;
    periph_map_pkg::pin_func_t pin_func_q [`PERIPH_PIN_W];

    assign ofs      = i_req.addr[5:0];
    assign wr       = (i_req.write_size != periph_bus_pkg::SIZE_NONE);
    // Function registers are word aligned from the base up to the slot end
    assign func_hit = (ofs >= `GPIO_FUNC_BASE) && (ofs[1:0] == 2'b00);
    assign func_idx = ofs[4:2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out_q <= '0;
        end else if (wr && ofs == `GPIO_OUT_OFS) begin
            gpio_out_q <= i_req.wdata[`PERIPH_PIN_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int p = 0; p < `PERIPH_PIN_W; p++) begin
                pin_func_q[p] <= periph_map_pkg::pin_func_t'(
                    (p < 2) ? `PIN_FUNC_RESET_LOW : `PIN_FUNC_RESET_HIGH);
            end
        end else if (wr && func_hit) begin
            pin_func_q[func_idx] <= periph_map_pkg::pin_func_t'(i_req.wdata[4:0]);
        end
    end

    always_comb begin
        o_rsp.rdata = '0;
        if (ofs == `GPIO_OUT_OFS) begin
            o_rsp.rdata[`PERIPH_PIN_W-1:0] = gpio_out_q;
        end else if (ofs == `GPIO_IN_OFS) begin
            o_rsp.rdata[`PERIPH_PIN_W-1:0] = i_ui_in;
        end else if (func_hit) begin
            o_rsp.rdata[4:0] = pin_func_q[func_idx];
        end
        o_rsp.ready = 1'b1;
        o_rsp.pins  = gpio_out_q;
    end

    assign o_pin_func = pin_func_q;

endmodule

//--- src/pin_out_mux.sv
/*
 * Output pin mux
 * Each pin takes its own bit from the peripheral chosen by its function
 */
`timescale 1ns/1ns
`include "periph_config.svh"

module pin_out_mux (
    input  periph_map_pkg::pin_func_t i_pin_func    [`PERIPH_PIN_W],
    input  logic [`PERIPH_PIN_W-1:0]  i_user_pins   [`PERIPH_SLOTS],
    input  logic [`PERIPH_PIN_W-1:0]  i_simple_pins [`PERIPH_SLOTS],
    output logic [`PERIPH_PIN_W-1:0]  o_uo_out
);

    logic [`PERIPH_PIN_W-1:0] user_bit;
    logic [`PERIPH_PIN_W-1:0] simple_bit;

    // Bit p of the slot named in function register p
    always_comb begin
        for (int p = 0; p < `PERIPH_PIN_W; p++) begin
            user_bit[p]   = i_user_pins[i_pin_func[p].slot][p];
            simple_bit[p] = i_simple_pins[i_pin_func[p].slot][p];
        end
    end

    always_comb begin
        for (int p = 0; p < `PERIPH_PIN_W; p++) begin
            if (i_pin_func[p].bank == periph_map_pkg::BANK_SIMPLE) begin
                o_uo_out[p] = simple_bit[p];
            end else begin
                o_uo_out[p] = user_bit[p];
            end
        end
    end

endmodule

//--- src/word_reg_periph.sv
/*
 * Word register peripheral
 * One 32-bit register with byte, half and word writes, plus an
 * interrupt flag set and cleared by writes
 */
`timescale 1ns/1ns
`include "periph_config.svh"

module word_reg_periph (
    input  logic                      clk,
    input  logic                      rst_n,
    input  periph_bus_pkg::bus_req_t  i_req,
    output periph_bus_pkg::slot_rsp_t o_rsp,
    output logic                      o_irq
);

    logic [5:0]                ofs;
    logic                      wr;
    logic [`PERIPH_DATA_W-1:0] word_q;
    logic                      irq_q;

    assign ofs = i_req.addr[5:0];
    assign wr  = (i_req.write_size != periph_bus_pkg::SIZE_NONE);

    // Narrow writes leave the upper bits alone
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            word_q <= '0;
        end else if (wr && ofs == 6'd0) begin
            case (i_req.write_size)
                periph_bus_pkg::SIZE_BYTE: word_q[7:0]  <= i_req.wdata[7:0];
                periph_bus_pkg::SIZE_HALF: word_q[15:0] <= i_req.wdata[15:0];
                default:                   word_q       <= i_req.wdata;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            irq_q <= 1'b0;
        end else if (wr && ofs == `WORD_IRQ_SET_OFS) begin
            irq_q <= 1'b1;
        end else if (wr && ofs == `WORD_IRQ_CLR_OFS) begin
            irq_q <= 1'b0;
        end
    end

    always_comb begin
        o_rsp.rdata = (ofs == 6'd0) ? word_q : '0;
        o_rsp.ready = 1'b1;
        o_rsp.pins  = word_q[`PERIPH_PIN_W-1:0];
    end

    assign o_irq = irq_q;

endmodule

//--- src/byte_reg_periph.sv
/*
 * Byte register peripheral
 * Four byte registers on the simple bus, register 0 drives the pins
 */
`timescale 1ns/1ns
`include "periph_config.svh"

module byte_reg_periph (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     i_wr,
    input  logic [3:0]               i_addr,
    input  logic [7:0]               i_wdata,
    output logic [7:0]               o_rdata,
    output logic [`PERIPH_PIN_W-1:0] o_pins
);

    logic       reg_hit;
    logic [7:0] regs_q [4];

    // Offsets 4 to 15 are unused
    assign reg_hit = (i_addr[3:2] == 2'b00);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < 4; r++) begin
                regs_q[r] <= 8'h00;
            end
        end else if (i_wr && reg_hit) begin
            regs_q[i_addr[1:0]] <= i_wdata;
        end
    end

    assign o_rdata = reg_hit ? regs_q[i_addr[1:0]] : 8'h00;
    assign o_pins  = regs_q[0];

endmodule

//--- src/tinyqv_periph_hub.sv
/*
 * Peripheral hub top level
 * Connects the address decoder, read buffer, GPIO, pin mux and the
 * word and byte register peripherals
 */
`timescale 1ns/1ns
`include "periph_config.svh"

module tinyqv_periph_hub (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`PERIPH_PIN_W-1:0]  i_ui_in,
    input  periph_bus_pkg::bus_req_t  i_req,
    input  logic                      i_data_read_complete,
    output logic [`PERIPH_PIN_W-1:0]  o_uo_out,
    output logic [`PERIPH_DATA_W-1:0] o_data_out,
    output logic                      o_data_ready,
    output logic                      o_irq
);

    wire periph_bus_pkg::bus_req_t  user_req [`PERIPH_SLOTS];
    wire periph_bus_pkg::slot_rsp_t user_rsp [`PERIPH_SLOTS];
    wire logic [`PERIPH_PIN_W-1:0]  user_pins [`PERIPH_SLOTS];
    wire logic [`PERIPH_PIN_W-1:0]  simple_pins [`PERIPH_SLOTS];
    periph_map_pkg::pin_func_t      pin_func [`PERIPH_PIN_W];
    logic                           simple_wr;
    logic [3:0]                     simple_addr;
    logic [7:0]                     simple_wdata;
    logic [7:0]                     simple_rdata;
    logic [`PERIPH_DATA_W-1:0]      rdata;
    logic                           rdy;

    // Empty slots, reserved slot 0 included, read zero and are always ready
    for (genvar s = 0; s < `PERIPH_SLOTS; s++) begin : g_slot
        if (s != `SLOT_GPIO && s != `SLOT_WORD_REG) begin : g_empty_user
            assign user_rsp[s] = '{rdata: '0, ready: 1'b1, pins: '0};
        end
        if (s != `SLOT_BYTE_REG) begin : g_empty_simple
            assign simple_pins[s] = '0;
        end
        assign user_pins[s] = user_rsp[s].pins;
    end

    periph_addr_decode u_decode (
        .i_req          (i_req),
        .i_user_rsp     (user_rsp),
        .i_simple_rdata (simple_rdata),
        .o_user_req     (user_req),
        .o_simple_wr    (simple_wr),
        .o_simple_addr  (simple_addr),
        .o_simple_wdata (simple_wdata),
        .o_rdata        (rdata),
        .o_rdy          (rdy)
    );

    periph_read_buffer u_read_buffer (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_read_size          (i_req.read_size),
        .i_write_size         (i_req.write_size),
        .i_rdata              (rdata),
        .i_rdy                (rdy),
        .i_data_read_complete (i_data_read_complete),
        .o_data_out           (o_data_out),
        .o_data_ready         (o_data_ready)
    );

    gpio_ctrl u_gpio (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_req      (user_req[`SLOT_GPIO]),
        .i_ui_in    (i_ui_in),
        .o_rsp      (user_rsp[`SLOT_GPIO]),
        .o_pin_func (pin_func)
    );

    word_reg_periph u_word_reg (
        .clk   (clk),
        .rst_n (rst_n),
        .i_req (user_req[`SLOT_WORD_REG]),
        .o_rsp (user_rsp[`SLOT_WORD_REG]),
        .o_irq (o_irq)
    );

    byte_reg_periph u_byte_reg (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_wr    (simple_wr),
        .i_addr  (simple_addr),
        .i_wdata (simple_wdata),
        .o_rdata (simple_rdata),
        .o_pins  (simple_pins[`SLOT_BYTE_REG])
    );

    pin_out_mux u_pin_mux (
        .i_pin_func    (pin_func),
        .i_user_pins   (user_pins),
        .i_simple_pins (simple_pins),
        .o_uo_out      (o_uo_out)
    );

endmodule

//--- bench/tb_periph_hub.sv
/*
 * Peripheral hub testbench
 * Replays the stimulus file and checks reads, pins and the interrupt
 */
`timescale 1ns/1ns
`include "periph_config.svh"

module tb_periph_hub;

    logic                      clk;
    logic                      rst_n;
    logic [`PERIPH_PIN_W-1:0]  i_ui_in;
    periph_bus_pkg::bus_req_t  req;
    logic                      i_data_read_complete;
    logic [`PERIPH_PIN_W-1:0]  o_uo_out;
    logic [`PERIPH_DATA_W-1:0] o_data_out;
    logic                      o_data_ready;
    logic                      o_irq;

    integer checks = 0;
    integer errors = 0;
    integer timeouts = 0;
    integer seed = 32'h143c_8ab6;
    logic   timed_out = 1'b0;

    tinyqv_periph_hub DUT (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_ui_in              (i_ui_in),
        .i_req                (req),
        .i_data_read_complete (i_data_read_complete),
        .o_uo_out             (o_uo_out),
        .o_data_out           (o_data_out),
        .o_data_ready         (o_data_ready),
        .o_irq                (o_irq)
    );

    always #4 clk = ~clk;

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input logic [10:0] addr, input string what);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("[FAIL] %0t ns: %s at %h is %h, expected %h", $time, what, addr, got, exp);
        end
    endtask

    task automatic release_bus();
        req.addr                = '0;
        req.wdata               = '0;
        req.write_size          = periph_bus_pkg::SIZE_NONE;
        req.read_size           = periph_bus_pkg::SIZE_NONE;
        i_data_read_complete    = 1'b0;
    endtask

    // Write is acknowledged in its own cycle
    task automatic write_access(input logic [1:0] size, input logic [10:0] addr,
                                input logic [31:0] wdata, input logic [7:0] ui);
        @(negedge clk);
        req.addr       = addr;
        req.wdata      = wdata;
        req.write_size = periph_bus_pkg::access_size_e'(size);
        i_ui_in        = ui;
        @(posedge clk);
        check_value({31'b0, o_data_ready}, 32'd1, addr, "write ready");
        @(negedge clk);
        release_bus();
    endtask

    // Held read, then a few cycles without read complete to check the hold
    task automatic read_access(input logic [1:0] size, input logic [10:0] addr,
                               input logic [7:0] ui, input logic [31:0] exp);
        integer cycles;
        integer hold;
        @(negedge clk);
        req.addr      = addr;
        req.read_size = periph_bus_pkg::access_size_e'(size);
        i_ui_in       = ui;
        cycles        = 0;
        while (!o_data_ready && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (!o_data_ready) begin
            timeouts++;
            timed_out = 1'b1;
            $display("Timed out after 20 cycles waiting for read data from address %h", addr);
        end else begin
            check_value(o_data_out, exp, addr, "read data");
            hold = 2 + ($unsigned($random(seed)) % 4);
            repeat (hold) begin
                @(negedge clk);
                i_ui_in = ~ui;
                check_value(o_data_out, exp, addr, "held read data");
            end
            @(negedge clk);
            req.read_size        = periph_bus_pkg::SIZE_NONE;
            i_data_read_complete = 1'b1;
            i_ui_in              = ui;
            @(negedge clk);
            i_data_read_complete = 1'b0;
        end
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    initial begin
        integer         fd;
        integer         c;
        integer         n;
        logic [1:0]     size;
        logic [10:0]    addr;
        logic [31:0]    wdata;
        logic [7:0]     ui;
        logic [31:0]    exp;
        clk     = 1'b0;
        rst_n   = 1'b0;
        i_ui_in = '0;
        release_bus();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // Read buffer comes out of reset empty and idle
        check_value({31'b0, o_data_ready}, 32'd0, 11'h000, "ready after reset");
        check_value(o_data_out, 32'd0, 11'h000, "read data after reset");
        fd = $fopen("bench/periph_hub_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the stimulus file bench/periph_hub_stim.txt");
        end else begin
            c = $fgetc(fd);
            while (c != -1 && !timed_out) begin
                if (c == "#") begin
                    // Comment line
                    while (c != "\n" && c != -1) begin
                        c = $fgetc(fd);
                    end
                end else if (c != " " && c != "\n" && c != "\r" && c != "\t") begin
                    n = $fscanf(fd, " %h %h %h %h %h", size, addr, wdata, ui, exp);
                    if (n != 5) begin
                        errors++;
                        $display("Stimulus line starting with %c could not be parsed", c);
                    end else if (c == "W") begin
                        write_access(size, addr, wdata, ui);
                    end else if (c == "R") begin
                        read_access(size, addr, ui, exp);
                    end else if (c == "P") begin
                        @(negedge clk);
                        i_ui_in = ui;
                        check_value({24'b0, o_uo_out}, exp, addr, "output pins");
                    end else if (c == "I") begin
                        @(negedge clk);
                        check_value({31'b0, o_irq}, exp, addr, "interrupt");
                    end else begin
                        errors++;
                        $display("Unknown stimulus operation %c", c);
                    end
                end
                c = $fgetc(fd);
            end
            $fclose(fd);
        end
        finish_run();
    end

endmodule

//--- tinyqv_periph_hub.f
+incdir+include
src/periph_bus_pkg.sv
src/periph_map_pkg.sv
src/periph_addr_decode.sv
src/periph_read_buffer.sv
src/gpio_ctrl.sv
src/pin_out_mux.sv
src/word_reg_periph.sv
src/byte_reg_periph.sv
src/tinyqv_periph_hub.sv
bench/tb_periph_hub.sv

//--- Bender.yml
package:
  name: tinyqv_periph_hub

export_include_dirs:
  - include

sources:
  - src/periph_bus_pkg.sv
  - src/periph_map_pkg.sv
  - src/periph_addr_decode.sv
  - src/periph_read_buffer.sv
  - src/gpio_ctrl.sv
  - src/pin_out_mux.sv
  - src/word_reg_periph.sv
  - src/byte_reg_periph.sv
  - src/tinyqv_periph_hub.sv
  - target: test
    files:
      - bench/tb_periph_hub.sv

//--- bench/periph_hub_stim.txt
# op size addr wdata ui_in expected (all hex)
# op W write, R read, P pins, I irq; size 0 byte, 1 half, 2 word, 3 none
R 2 060 00000000 00 00000004
R 2 064 00000000 00 00000004
R 2 068 00000000 00 00000001
R 2 07c 00000000 00 00000001
R 2 040 00000000 00 00000000
R 2 100 00000000 00 00000000
I 3 000 00000000 00 00000000
P 3 000 00000000 00 00000000
W 2 040 000000ff 00 00000000
P 3 000 00000000 00 000000fc
W 2 040 0000005a 00 00000000
R 2 040 00000000 00 0000005a
P 3 000 00000000 00 00000058
R 2 044 00000000 a5 000000a5
W 2 100 1234567b 00 00000000
R 2 100 00000000 00 1234567b
P 3 000 00000000 00 0000005b
W 0 100 aabbccde 00 00000000
R 2 100 00000000 00 123456de
W 1 100 99887766 00 00000000
R 2 100 00000000 00 12347766
P 3 000 00000000 00 0000005a
W 0 400 000000f0 00 00000000
W 0 403 0000003c 00 00000000
R 0 403 00000000 00 0000003c
W 2 07c 00000010 00 00000000
P 3 000 00000000 00 000000da
W 2 078 00000017 00 00000000
P 3 000 00000000 00 0000009a
W 2 070 00000007 00 00000000
P 3 000 00000000 00 0000008a
R 2 070 00000000 00 00000007
W 2 104 00000000 00 00000000
I 3 000 00000000 00 00000001
W 2 108 00000000 00 00000000
I 3 000 00000000 00 00000000
R 2 000 00000000 00 00000000
R 2 1c0 00000000 00 00000000
R 2 430 00000000 00 00000000
R 0 40c 00000000 00 00000000
